// File: mem_pkg.sv
package mem_pkg;

	// memory geometry
	localparam int word_addr_width = 10;                        // 1024 words
	localparam int mem_depth       = 1 << word_addr_width;
	localparam int data_width      = 64;
	localparam int byte_width      = 8;
	localparam int bytes_per_word  = data_width / byte_width;
	localparam int offset_width    = $clog2(bytes_per_word);
	localparam int byte_addr_width = word_addr_width + offset_width;

	// edges from request at the ram input to data at the ram output
	localparam int read_latency = 2;

	// access size codes as log2 of the byte count
	localparam logic [1:0] size_byte  = 2'd0;
	localparam logic [1:0] size_half  = 2'd1;
	localparam logic [1:0] size_word  = 2'd2;
	localparam logic [1:0] size_dword = 2'd3;

	// one memory word seen whole or as byte lanes
	typedef union packed {
		logic [data_width-1:0]                    word;
		logic [bytes_per_word-1:0][byte_width-1:0] lanes; // lane 0 in low bits
	} mem_view_t;

endpackage

// File: ram_single_port.sv
module ram_single_port (
	input  logic                                 clk,
	input  logic                                 en,
	input  logic [mem_pkg::word_addr_width-1:0]  addr,
	input  logic [mem_pkg::bytes_per_word-1:0]   strobe,
	input  mem_pkg::mem_view_t                   wdata,
	output logic [mem_pkg::data_width-1:0]       rdata
);

	mem_pkg::mem_view_t mem [mem_pkg::mem_depth];

	// read pipeline with stage 0 loaded straight from the array
	logic [mem_pkg::data_width-1:0] reads [mem_pkg::read_latency];

	initial begin
		for (int i = 0; i < mem_pkg::mem_depth; i++) begin
			mem[i] = '0;
		end
	end

	// per lane write
	always @(posedge clk) begin
		if (en) begin
			for (int i = 0; i < mem_pkg::bytes_per_word; i++) begin
				if (strobe[i]) begin
					mem[addr].lanes[i] <= wdata.lanes[i];
				end
			end
		end
	end

	// read-first since the write above is non-blocking
	always_ff @(posedge clk) begin
		if (en) begin
			reads[0] <= mem[addr].word;
		end
		for (int i = 1; i < mem_pkg::read_latency; i++) begin
			reads[i] <= reads[i-1];
		end
	end

	assign rdata = reads[mem_pkg::read_latency-1];

	a_strobe_needs_en: assert property (
		@(posedge clk) !en |-> strobe == '0
	) else $error("ram_single_port: strobe %h set while en is low", strobe);

endmodule

// File: store_align.sv
module store_align (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 req,
	input  logic                                 we,
	input  logic [mem_pkg::byte_addr_width-1:0]  addr,
	input  logic [1:0]                           size,
	input  logic                                 unsigned_load,
	input  logic [mem_pkg::data_width-1:0]       wdata,
	output logic                                 en,
	output logic [mem_pkg::word_addr_width-1:0]  word_addr,
	output logic [mem_pkg::bytes_per_word-1:0]   strobe,
	output mem_pkg::mem_view_t                   lane_wdata,
	output logic                                 load_issue,
	output logic [mem_pkg::offset_width-1:0]     offset,
	output logic [1:0]                           load_size,
	output logic                                 load_unsigned,
	output logic                                 misaligned
);

	logic                                 aligned;
	logic [mem_pkg::bytes_per_word-1:0]   lane_mask;   // size-wide mask at lane 0
	logic [mem_pkg::offset_width-1:0]     index_mask;  // byte count minus one
	mem_pkg::mem_view_t                   wdata_view;

	assign wdata_view.word = wdata;
	assign offset          = addr[mem_pkg::offset_width-1:0];
	assign word_addr       = addr[mem_pkg::byte_addr_width-1:mem_pkg::offset_width];

	always_comb begin
		aligned    = 1'b1;
		lane_mask  = 8'h01;
		index_mask = 3'd0;
		case (size)
			mem_pkg::size_half: begin
				aligned    = addr[0] == 1'b0;
				lane_mask  = 8'h03;
				index_mask = 3'd1;
			end
			mem_pkg::size_word: begin
				aligned    = addr[1:0] == 2'b00;
				lane_mask  = 8'h0f;
				index_mask = 3'd3;
			end
			mem_pkg::size_dword: begin
				aligned    = addr[2:0] == 3'b000;
				lane_mask  = 8'hff;
				index_mask = 3'd7;
			end
			default: ; // single byte is always aligned
		endcase
	end

	assign en            = req && aligned;
	assign load_issue    = en && !we;
	assign load_size     = size;
	assign load_unsigned = unsigned_load;
	assign strobe        = (en && we) ? lane_mask << offset : '0;

	// repeat the low bytes so whichever lanes are strobed see the right data
	always_comb begin
		for (int i = 0; i < mem_pkg::bytes_per_word; i++) begin
			lane_wdata.lanes[i] = wdata_view.lanes[i & index_mask];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			misaligned <= 1'b0;
		end else begin
			misaligned <= req && !aligned;
		end
	end

	a_strobe_window: assert property (
		@(posedge clk) disable iff (rst)
		strobe != '0 |-> strobe inside {8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40,
			8'h80, 8'h03, 8'h0c, 8'h30, 8'hc0, 8'h0f, 8'hf0, 8'hff}
	) else $error("store_align: strobe %h outside an aligned window", strobe);

endmodule

// File: load_align.sv
module load_align (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              load_issue,
	input  logic [mem_pkg::offset_width-1:0]  offset,
	input  logic [1:0]                        load_size,
	input  logic                              load_unsigned,
	input  logic [mem_pkg::data_width-1:0]    ram_rdata,
	output logic                              rvalid,
	output logic [mem_pkg::data_width-1:0]    rdata
);

	localparam int last = mem_pkg::read_latency - 1;

	// delay line that tracks the ram read pipeline
	logic [mem_pkg::read_latency-1:0]                            pipe_valid;
	logic [mem_pkg::read_latency-1:0][mem_pkg::offset_width-1:0] pipe_offset;
	logic [mem_pkg::read_latency-1:0][1:0]                       pipe_size;
	logic [mem_pkg::read_latency-1:0]                            pipe_unsigned;

	mem_pkg::mem_view_t                ram_view;
	mem_pkg::mem_view_t                sel_view;  // addressed lanes moved down to lane 0
	logic                              fill;
	logic [mem_pkg::data_width-1:0]    extended;

	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_valid <= '0;
		end else begin
			pipe_valid[0] <= load_issue;
			for (int i = 1; i < mem_pkg::read_latency; i++) begin
				pipe_valid[i] <= pipe_valid[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		pipe_offset[0]   <= offset;
		pipe_size[0]     <= load_size;
		pipe_unsigned[0] <= load_unsigned;
		for (int i = 1; i < mem_pkg::read_latency; i++) begin
			pipe_offset[i]   <= pipe_offset[i-1];
			pipe_size[i]     <= pipe_size[i-1];
			pipe_unsigned[i] <= pipe_unsigned[i-1];
		end
	end

	assign ram_view.word = ram_rdata;

	always_comb begin
		for (int i = 0; i < mem_pkg::bytes_per_word; i++) begin
			sel_view.lanes[i] = ram_view.lanes[(i + pipe_offset[last]) % mem_pkg::bytes_per_word];
		end
	end

	always_comb begin
		fill     = 1'b0;
		extended = sel_view.word;
		case (pipe_size[last])
			mem_pkg::size_byte: begin
				fill     = !pipe_unsigned[last] && sel_view.word[7];
				extended = {{(mem_pkg::data_width - 8){fill}}, sel_view.word[7:0]};
			end
			mem_pkg::size_half: begin
				fill     = !pipe_unsigned[last] && sel_view.word[15];
				extended = {{(mem_pkg::data_width - 16){fill}}, sel_view.word[15:0]};
			end
			mem_pkg::size_word: begin
				fill     = !pipe_unsigned[last] && sel_view.word[31];
				extended = {{(mem_pkg::data_width - 32){fill}}, sel_view.word[31:0]};
			end
			default: ; // double word needs no extension
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			rvalid <= 1'b0;
		end else begin
			rvalid <= pipe_valid[last];
		end
	end

	always_ff @(posedge clk) begin
		if (pipe_valid[last]) begin
			rdata <= extended;
		end
	end

	// every result traces back to an issued load read_latency + 1 cycles before
	a_rvalid_from_issue: assert property (
		@(posedge clk) disable iff (rst)
		rvalid |-> $past(load_issue, mem_pkg::read_latency + 1)
	) else $error("load_align: rvalid without a load issued %0d cycles earlier",
		mem_pkg::read_latency + 1);

endmodule

// File: data_mem.sv
module data_mem (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 req,
	input  logic                                 we,
	input  logic [mem_pkg::byte_addr_width-1:0]  addr,
	input  logic [1:0]                           size,
	input  logic                                 unsigned_load,
	input  logic [mem_pkg::data_width-1:0]       wdata,
	output logic                                 rvalid,
	output logic [mem_pkg::data_width-1:0]       rdata,
	output logic                                 misaligned
);

	logic                                 ram_en;
	logic [mem_pkg::word_addr_width-1:0]  ram_addr;
	logic [mem_pkg::bytes_per_word-1:0]   ram_strobe;
	mem_pkg::mem_view_t                   ram_wdata;
	logic [mem_pkg::data_width-1:0]       ram_rdata;

	logic                                 load_issue;
	logic [mem_pkg::offset_width-1:0]     load_offset;
	logic [1:0]                           load_size;
	logic                                 load_unsigned;

	store_align u_store_align (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.we            (we),
		.addr          (addr),
		.size          (size),
		.unsigned_load (unsigned_load),
		.wdata         (wdata),
		.en            (ram_en),
		.word_addr     (ram_addr),
		.strobe        (ram_strobe),
		.lane_wdata    (ram_wdata),
		.load_issue    (load_issue),
		.offset        (load_offset),
		.load_size     (load_size),
		.load_unsigned (load_unsigned),
		.misaligned    (misaligned)
	);

	ram_single_port u_ram (
		.clk    (clk),
		.en     (ram_en),
		.addr   (ram_addr),
		.strobe (ram_strobe),
		.wdata  (ram_wdata),
		.rdata  (ram_rdata)
	);

	load_align u_load_align (
		.clk           (clk),
		.rst           (rst),
		.load_issue    (load_issue),
		.offset        (load_offset),
		.load_size     (load_size),
		.load_unsigned (load_unsigned),
		.ram_rdata     (ram_rdata),
		.rvalid        (rvalid),
		.rdata         (rdata)
	);

endmodule

// File: mem_checker.sv
module mem_checker (
	input  logic                                 clk,
	input  logic                                 rst,
	input  logic                                 req,
	input  logic                                 we,
	input  logic [mem_pkg::byte_addr_width-1:0]  addr,
	input  logic [1:0]                           size,
	input  logic                                 unsigned_load,
	input  logic [mem_pkg::data_width-1:0]       wdata,
	input  logic                                 rvalid,
	input  logic [mem_pkg::data_width-1:0]       rdata,
	input  logic                                 misaligned,
	input  logic                                 table_check,
	input  logic [mem_pkg::data_width-1:0]       table_value,
	output int                                   value_errors,
	output int                                   rvalid_errors,
	output int                                   misaligned_errors,
	output int                                   pending
);

	localparam int load_delay = mem_pkg::read_latency + 1;  // req to rvalid
	localparam int mem_bytes  = mem_pkg::mem_depth * mem_pkg::bytes_per_word;

	logic [7:0]  model [mem_bytes];
	int          cycle;
	logic        mis_due;        // a misaligned pulse is owed this cycle
	int          due_q[$];
	logic [63:0] model_q[$];
	logic        check_q[$];
	logic [63:0] table_q[$];

	initial begin
		for (int i = 0; i < mem_bytes; i++) begin
			model[i] = 8'h00;
		end
		cycle             = 0;
		mis_due           = 1'b0;
		value_errors      = 0;
		rvalid_errors     = 0;
		misaligned_errors = 0;
		pending           = 0;
	end

	function automatic logic is_aligned(input logic [12:0] a, input logic [1:0] s);
		return (a & ((13'd1 << s) - 13'd1)) == 13'd0;
	endfunction

	// little endian bytes from the model, then sign or zero fill
	function automatic logic [63:0] expected_load(input logic [12:0] a, input logic [1:0] s,
			input logic u);
		int          n;
		logic [63:0] v;
		n = 1 << s;
		v = '0;
		for (int i = n - 1; i >= 0; i--) begin
			v = {v[55:0], model[a + i]};
		end
		if (!u && n < 8 && v[8*n-1]) begin
			for (int b = 8 * n; b < 64; b++) begin
				v[b] = 1'b1;
			end
		end
		return v;
	endfunction

	task automatic store_bytes(input logic [12:0] a, input logic [1:0] s, input logic [63:0] d);
		for (int i = 0; i < (1 << s); i++) begin
			model[a + i] = d[8*i +: 8];
		end
	endtask

	always @(posedge clk) begin
		cycle = cycle + 1;
		if (rst) begin
			due_q.delete();
			model_q.delete();
			check_q.delete();
			table_q.delete();
			mis_due = 1'b0;
		end else begin
			if (misaligned !== mis_due) begin
				if (mis_due) begin
					$display("misaligned did not pulse after a misaligned request at time %0t",
						$time);
				end else begin
					$display("misaligned pulsed without a misaligned request at time %0t", $time);
				end
				misaligned_errors++;
			end
			mis_due = req && !is_aligned(addr, size);

			if (due_q.size() != 0 && due_q[0] == cycle) begin
				if (rvalid !== 1'b1) begin
					$display("rvalid missing at time %0t for a load issued 3 cycles earlier", $time);
					rvalid_errors++;
				end else begin
					if (rdata !== model_q[0]) begin
						$display("[ERROR] time %0t rdata expected %h actual %h",
							$time, model_q[0], rdata);
						value_errors++;
					end
					if (check_q[0] && rdata !== table_q[0]) begin
						$display("[ERROR] time %0t rdata (table) expected %h actual %h",
							$time, table_q[0], rdata);
						value_errors++;
					end
				end
				void'(due_q.pop_front());
				void'(model_q.pop_front());
				void'(check_q.pop_front());
				void'(table_q.pop_front());
			end else if (rvalid !== 1'b0) begin
				$display("unexpected rvalid at time %0t with no load due", $time);
				rvalid_errors++;
			end

			if (req && is_aligned(addr, size)) begin
				if (we) begin
					store_bytes(addr, size, wdata);
				end else begin
					due_q.push_back(cycle + load_delay);
					model_q.push_back(expected_load(addr, size, unsigned_load));
					check_q.push_back(table_check);
					table_q.push_back(table_value);
				end
			end
		end
		pending <= due_q.size() + int'(mis_due);
	end

endmodule

// File: tb_data_mem.sv
module tb_data_mem;

	localparam int drain_limit     = 50;   // cycles
	localparam int random_requests = 300;

	typedef struct packed {
		logic        we;
		logic [12:0] addr;
		logic [1:0]  size;
		logic        unsigned_load;
		logic [63:0] wdata;
		logic [63:0] result;  // expected load data
		logic        check;   // compare result on this load
		logic [3:0]  idle;    // idle cycles after the request
	} step_t;

	logic                                 clk;
	logic                                 rst;
	logic                                 req;
	logic                                 we;
	logic [mem_pkg::byte_addr_width-1:0]  addr;
	logic [1:0]                           size;
	logic                                 unsigned_load;
	logic [mem_pkg::data_width-1:0]       wdata;
	logic                                 rvalid;
	logic [mem_pkg::data_width-1:0]       rdata;
	logic                                 misaligned;
	logic                                 table_check;
	logic [mem_pkg::data_width-1:0]       table_value;

	int    value_errors;
	int    rvalid_errors;
	int    misaligned_errors;
	int    pending;
	step_t steps[$];

	data_mem u_dut (
		.clk           (clk),
		.rst           (rst),
		.req           (req),
		.we            (we),
		.addr          (addr),
		.size          (size),
		.unsigned_load (unsigned_load),
		.wdata         (wdata),
		.rvalid        (rvalid),
		.rdata         (rdata),
		.misaligned    (misaligned)
	);

	mem_checker u_check (
		.clk               (clk),
		.rst               (rst),
		.req               (req),
		.we                (we),
		.addr              (addr),
		.size              (size),
		.unsigned_load     (unsigned_load),
		.wdata             (wdata),
		.rvalid            (rvalid),
		.rdata             (rdata),
		.misaligned        (misaligned),
		.table_check       (table_check),
		.table_value       (table_value),
		.value_errors      (value_errors),
		.rvalid_errors     (rvalid_errors),
		.misaligned_errors (misaligned_errors),
		.pending           (pending)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic add_step(input logic w, input logic [12:0] a, input logic [1:0] s,
			input logic u, input logic [63:0] d, input logic [63:0] r, input logic c,
			input int idle);
		steps.push_back({w, a, s, u, d, r, c, 4'(idle)});
	endtask

	task automatic send_request(input logic w, input logic [12:0] a, input logic [1:0] s,
			input logic u, input logic [63:0] d, input logic [63:0] r, input logic c);
		@(posedge clk);
		req           <= 1'b1;
		we            <= w;
		addr          <= a;
		size          <= s;
		unsigned_load <= u;
		wdata         <= d;
		table_value   <= r;
		table_check   <= c;
	endtask

	task automatic idle_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
			req         <= 1'b0;
			table_check <= 1'b0;
		end
	endtask

	task automatic build_table();
		// never written words read back as zero
		add_step(1'b0, 13'h100, mem_pkg::size_dword, 1'b0, '0, 64'h0, 1'b1, 0);
		add_step(1'b0, 13'h105, mem_pkg::size_byte, 1'b0, '0, 64'h0, 1'b1, 2);
		add_step(1'b1, 13'h020, mem_pkg::size_dword, 1'b0, 64'h0123_4567_89ab_cdef, '0, 1'b0, 0);
		add_step(1'b0, 13'h020, mem_pkg::size_dword, 1'b0, '0, 64'h0123_4567_89ab_cdef, 1'b1, 3);
		// sign and zero extension
		add_step(1'b0, 13'h020, mem_pkg::size_byte, 1'b0, '0, 64'hffff_ffff_ffff_ffef, 1'b1, 0);
		add_step(1'b0, 13'h020, mem_pkg::size_byte, 1'b1, '0, 64'h0000_0000_0000_00ef, 1'b1, 0);
		add_step(1'b0, 13'h024, mem_pkg::size_byte, 1'b0, '0, 64'h0000_0000_0000_0067, 1'b1, 0);
		add_step(1'b0, 13'h022, mem_pkg::size_half, 1'b0, '0, 64'hffff_ffff_ffff_89ab, 1'b1, 0);
		add_step(1'b0, 13'h022, mem_pkg::size_half, 1'b1, '0, 64'h0000_0000_0000_89ab, 1'b1, 0);
		add_step(1'b0, 13'h026, mem_pkg::size_half, 1'b0, '0, 64'h0000_0000_0000_0123, 1'b1, 0);
		add_step(1'b0, 13'h020, mem_pkg::size_word, 1'b0, '0, 64'hffff_ffff_89ab_cdef, 1'b1, 0);
		add_step(1'b0, 13'h024, mem_pkg::size_word, 1'b0, '0, 64'h0000_0000_0123_4567, 1'b1, 0);
		add_step(1'b0, 13'h020, mem_pkg::size_word, 1'b1, '0, 64'h0000_0000_89ab_cdef, 1'b1, 2);
		// narrow stores keep the other lanes
		add_step(1'b1, 13'h040, mem_pkg::size_dword, 1'b0, 64'h8877_6655_4433_2211, '0, 1'b0, 0);
		add_step(1'b1, 13'h043, mem_pkg::size_byte, 1'b0, 64'hdead_beef_0000_00a5, '0, 1'b0, 0);
		add_step(1'b1, 13'h046, mem_pkg::size_half, 1'b0, 64'hffff_ffff_ffff_c3b4, '0, 1'b0, 0);
		add_step(1'b1, 13'h040, mem_pkg::size_word, 1'b0, 64'h1234_5678_0bad_f00d, '0, 1'b0, 0);
		add_step(1'b0, 13'h040, mem_pkg::size_dword, 1'b0, '0, 64'hc3b4_6655_0bad_f00d, 1'b1, 1);
		for (int o = 0; o < 8; o++) begin
			add_step(1'b1, 13'h060 + 13'(o), mem_pkg::size_byte, 1'b0,
				64'hcccc_cccc_cccc_cc10 + 64'(o), '0, 1'b0, 0);
		end
		add_step(1'b0, 13'h060, mem_pkg::size_dword, 1'b0, '0, 64'h1716_1514_1312_1110, 1'b1, 0);
		for (int o = 0; o < 8; o += 2) begin
			add_step(1'b1, 13'h068 + 13'(o), mem_pkg::size_half, 1'b0,
				64'h5555_5555_5555_a0b0 + 64'(o * 'h101), '0, 1'b0, 0);
		end
		add_step(1'b0, 13'h068, mem_pkg::size_dword, 1'b0, '0, 64'ha6b6_a4b4_a2b2_a0b0, 1'b1, 0);
		add_step(1'b1, 13'h070, mem_pkg::size_word, 1'b0, 64'h7777_7777_cafe_0001, '0, 1'b0, 0);
		add_step(1'b1, 13'h074, mem_pkg::size_word, 1'b0, 64'h7777_7777_cafe_0002, '0, 1'b0, 0);
		add_step(1'b0, 13'h070, mem_pkg::size_dword, 1'b0, '0, 64'hcafe_0002_cafe_0001, 1'b1, 2);
		// misaligned requests leave word 0x40 alone
		add_step(1'b1, 13'h041, mem_pkg::size_half, 1'b0, 64'hffff, '0, 1'b0, 0);
		add_step(1'b1, 13'h042, mem_pkg::size_word, 1'b0, 64'hffff_ffff, '0, 1'b0, 0);
		add_step(1'b1, 13'h044, mem_pkg::size_dword, 1'b0, '1, '0, 1'b0, 0);
		add_step(1'b0, 13'h046, mem_pkg::size_word, 1'b0, '0, '0, 1'b0, 1);
		add_step(1'b0, 13'h040, mem_pkg::size_dword, 1'b0, '0, 64'hc3b4_6655_0bad_f00d, 1'b1, 2);
		// back to back with loads right after stores to the same word
		add_step(1'b1, 13'h080, mem_pkg::size_dword, 1'b0, 64'h5a5a_0000_ffff_1234, '0, 1'b0, 0);
		add_step(1'b0, 13'h080, mem_pkg::size_half, 1'b0, '0, 64'h0000_0000_0000_1234, 1'b1, 0);
		add_step(1'b1, 13'h081, mem_pkg::size_byte, 1'b0, 64'h99, '0, 1'b0, 0);
		add_step(1'b0, 13'h080, mem_pkg::size_half, 1'b0, '0, 64'hffff_ffff_ffff_9934, 1'b1, 0);
		add_step(1'b0, 13'h084, mem_pkg::size_word, 1'b1, '0, 64'h0000_0000_5a5a_0000, 1'b1, 0);
		add_step(1'b0, 13'h080, mem_pkg::size_dword, 1'b0, '0, 64'h5a5a_0000_ffff_9934, 1'b1, 4);
	endtask

	task automatic run_random(input int count);
		logic [1:0]  s;
		logic [2:0]  off;
		logic [12:0] a;
		for (int i = 0; i < count; i++) begin
			s   = 2'($urandom % 4);
			off = 3'($urandom % 8) & ~3'((1 << s) - 1);
			if ($urandom % 8 == 0) begin
				s   = 2'(1 + $urandom % 3);  // an odd offset misaligns these sizes
				off = 3'($urandom % 8) | 3'd1;
			end
			a = {10'(64 + $urandom % 8), off};
			send_request(1'($urandom % 2), a, s, 1'($urandom % 2), {$urandom, $urandom}, '0, 1'b0);
			if ($urandom % 4 == 0) begin
				idle_cycles(1);
			end
		end
	endtask

	initial begin
		int timeouts;
		int waited;
		timeouts = 0;
		waited   = 0;
		void'($urandom(32'hccc7));
		rst           = 1'b1;
		req           = 1'b0;
		we            = 1'b0;
		addr          = '0;
		size          = '0;
		unsigned_load = 1'b0;
		wdata         = '0;
		table_check   = 1'b0;
		table_value   = '0;
		build_table();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		idle_cycles(3);  // outputs must stay quiet here
		foreach (steps[i]) begin
			send_request(steps[i].we, steps[i].addr, steps[i].size, steps[i].unsigned_load,
				steps[i].wdata, steps[i].result, steps[i].check);
			idle_cycles(steps[i].idle);
		end
		run_random(random_requests);
		idle_cycles(1);
		do begin
			@(negedge clk);
			waited++;
		end while (pending != 0 && waited < drain_limit);
		if (pending != 0) begin
			$display("timeout: %0d results still outstanding after %0d cycles", pending, waited);
			timeouts++;
		end
		$display("error counts: value %0d, rvalid %0d, misaligned %0d, timeout %0d",
			value_errors, rvalid_errors, misaligned_errors, timeouts);
		if (value_errors + rvalid_errors + misaligned_errors + timeouts == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

// File: data_mem.f
mem_pkg.sv
ram_single_port.sv
store_align.sv
load_align.sv
data_mem.sv
mem_checker.sv
tb_data_mem.sv
